/* vlog.f */
rob_pkg.sv
rob_alloc_if.sv
rob_head_if.sv
rob_dispatch.sv
rob_buffer.sv
rob_retire.sv
rob_top.sv
rob_chk.sv
rob_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rob_tb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* rob_tb.sv */
module rob_tb;
    import rob_pkg::*;

    localparam logic [31:0] SEED        = 32'h0017_021d;
    localparam int          CLK_PERIOD  = 40;
    localparam int          DRIVE_DLY   = 2;
    localparam int          TIMEOUT     = 2000;
    localparam int          N_RANDOM    = 500;
    localparam int          MIN_COMMITS = 200;

    typedef struct packed {
        rob_tag_t tag;
        reg_idx_t rd;
        logic     is_store;
        logic     pred_taken;
        logic     taken;
        data_t    data;
        data_t    target;
        logic     completed;
    } instr_t;

    typedef struct packed {
        logic     rf_we;
        reg_idx_t rd;
        data_t    data;
        logic     store;
        rob_tag_t tag;
        logic     redirect;
        data_t    pc;
    } commit_t;

    logic     clk;
    logic     rst_n;
    logic     disp_valid;
    reg_idx_t disp_rd;
    logic     disp_is_store;
    logic     disp_pred_taken;
    logic     disp_ready;
    rob_tag_t disp_tag;
    logic     cpl_valid;
    rob_tag_t cpl_tag;
    data_t    cpl_data;
    logic     cpl_taken;
    data_t    cpl_target;
    logic     retire_ready;
    logic     rf_we;
    reg_idx_t rf_rd;
    data_t    rf_data;
    logic     store_commit;
    rob_tag_t store_tag;
    logic     redirect_valid;
    data_t    redirect_pc;

    // dispatched, not yet committed, oldest first
    instr_t      pending[$];
    logic [31:0] rng;
    rob_tag_t    next_tag;
    int          commits;
    int          p_store;
    int          p_branch;
    int          p_bogus;
    int          p_retire;
    logic        want_disp;
    logic        marker;
    logic        last_sent;

    rob_top dut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rnd();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic rand_pct(input int p);
        return (rnd() % 100) < p;
    endfunction

    // what the head instruction must show when it retires
    function automatic commit_t expected_commit(input instr_t in);
        commit_t c;
        c.rf_we    = !in.is_store && (in.rd != '0);
        c.rd       = in.rd;
        c.data     = in.data;
        c.store    = in.is_store;
        c.tag      = in.tag;
        c.redirect = in.taken != in.pred_taken;
        c.pc       = in.target;
        return c;
    endfunction

    function automatic logic visible(input commit_t c);
        return c.rf_we || c.store || c.redirect;
    endfunction

    // outstanding instructions holding this tag
    function automatic int tag_uses(input rob_tag_t t);
        int n;
        n = 0;
        foreach (pending[i]) begin
            if (pending[i].tag == t) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic instr_t new_instr();
        instr_t in;
        int     kind;
        kind          = rnd() % 100;
        in.tag        = next_tag;
        in.rd         = reg_idx_t'(rnd());
        in.data       = rnd();
        in.target     = rnd();
        in.is_store   = 1'b0;
        in.pred_taken = 1'b0;
        in.taken      = 1'b0;
        in.completed  = 1'b0;
        if (rand_pct(10)) begin
            in.rd = '0;
        end
        if (marker) begin
            in.rd = reg_idx_t'(rnd() % 31 + 1);
        end else if (kind < p_store) begin
            in.is_store = 1'b1;
        end else if (kind < p_store + p_branch) begin
            in.pred_taken = rand_pct(50);
            in.taken      = rand_pct(50);
        end
        return in;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_rf(input reg_idx_t rd, input data_t data,
                            input reg_idx_t exp_rd, input data_t exp_data);
        if (rd !== exp_rd) begin
            stop_on_error($sformatf("mismatch rf_rd: got %h expected %h", rd, exp_rd));
        end
        if (data !== exp_data) begin
            stop_on_error($sformatf("mismatch rf_data: got %h expected %h", data, exp_data));
        end
    endtask

    task automatic check_store(input rob_tag_t tag, input rob_tag_t exp);
        if (tag !== exp) begin
            stop_on_error($sformatf("mismatch store_tag: got %h expected %h", tag, exp));
        end
    endtask

    task automatic check_redirect(input data_t pc, input data_t exp);
        if (pc !== exp) begin
            stop_on_error($sformatf("mismatch redirect_pc: got %h expected %h", pc, exp));
        end
    endtask

    task automatic check_tag(input rob_tag_t tag, input rob_tag_t exp);
        if (tag !== exp) begin
            stop_on_error($sformatf("mismatch disp_tag: got %h expected %h", tag, exp));
        end
    endtask

    task automatic drive_cpl(input rob_tag_t tag, input data_t data, input logic taken,
                             input data_t target);
        cpl_valid  = 1'b1;
        cpl_tag    = tag;
        cpl_data   = data;
        cpl_taken  = taken;
        cpl_target = target;
    endtask

    // one clock of stimulus: maybe a completion, maybe a dispatch
    task automatic step();
        instr_t   in;
        int       idx;
        rob_tag_t bad;
        @(posedge clk);
        #DRIVE_DLY;
        last_sent    = 1'b0;
        disp_valid   = 1'b0;
        cpl_valid    = 1'b0;
        retire_ready = rand_pct(p_retire);
        if (redirect_valid) begin
            // buffer is flushing, tags start over
            next_tag = '0;
            return;
        end
        if (pending.size() != 0 && rand_pct(60)) begin
            idx = rnd() % pending.size();
            if (!pending[idx].completed) begin
                pending[idx].completed = 1'b1;
                drive_cpl(pending[idx].tag, pending[idx].data, pending[idx].taken,
                          pending[idx].target);
            end else if (tag_uses(pending[idx].tag) == 1 && rand_pct(p_bogus)) begin
                // a silently retired slot may already hold a newer instruction
                drive_cpl(pending[idx].tag, rnd(), rand_pct(50), rnd());
            end
        end else if (pending.size() < ROB_DEPTH && rand_pct(p_bogus)) begin
            bad = rob_tag_t'(rnd());
            if (tag_uses(bad) == 0) begin
                drive_cpl(bad, rnd(), rand_pct(50), rnd());
            end
        end
        if (want_disp && disp_ready) begin
            check_tag(disp_tag, next_tag);
            in = new_instr();
            pending.push_back(in);
            disp_valid      = 1'b1;
            disp_rd         = in.rd;
            disp_is_store   = in.is_store;
            disp_pred_taken = in.pred_taken;
            next_tag        = next_tag + 1'b1;
            last_sent       = 1'b1;
        end
    endtask

    // last instruction always writes, so its commit shows everything older is gone
    task automatic drain();
        int t;
        want_disp = 1'b1;
        marker    = 1'b1;
        p_retire  = 100;
        t         = 0;
        while (want_disp || pending.size() != 0) begin
            step();
            if (last_sent) begin
                want_disp = 1'b0;
                marker    = 1'b0;
            end
            t++;
            if (t == TIMEOUT) begin
                stop_on_error("timeout while draining the reorder buffer");
            end
        end
    endtask

    task automatic run_mix(input int n, input int ps, input int pb, input int pg,
                           input int pr);
        int sent_n;
        int t;
        p_store   = ps;
        p_branch  = pb;
        p_bogus   = pg;
        p_retire  = pr;
        want_disp = 1'b1;
        marker    = 1'b0;
        sent_n    = 0;
        t         = 0;
        while (sent_n < n) begin
            step();
            if (last_sent) begin
                sent_n++;
                t = 0;
            end else begin
                t++;
            end
            if (t == TIMEOUT) begin
                stop_on_error("timeout waiting for disp_ready");
            end
        end
        drain();
    endtask

    task automatic fill_blocked();
        int sent_n;
        int t;
        p_store   = 0;
        p_branch  = 0;
        p_bogus   = 0;
        p_retire  = 0;
        want_disp = 1'b1;
        marker    = 1'b0;
        sent_n    = 0;
        t         = 0;
        while (sent_n < ROB_DEPTH) begin
            step();
            if (last_sent) begin
                sent_n++;
            end
            t++;
            if (t == TIMEOUT) begin
                stop_on_error("timeout filling the buffer with retirement stalled");
            end
        end
        repeat (8) begin
            step();
            if (last_sent || disp_ready) begin
                stop_on_error("dispatch still possible with every credit in use");
            end
        end
        drain();
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // commit checker, samples mid-cycle
    initial begin
        commit_t exp;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && (rf_we || store_commit || redirect_valid)) begin
                // silent commits leave no pulse
                while (pending.size() != 0 && !visible(expected_commit(pending[0]))) begin
                    void'(pending.pop_front());
                end
                if (pending.size() == 0) begin
                    stop_on_error("commit pulse with no instruction outstanding");
                end else begin
                    exp = expected_commit(pending[0]);
                    void'(pending.pop_front());
                    check_flag("rf_we", rf_we, exp.rf_we);
                    check_flag("store_commit", store_commit, exp.store);
                    check_flag("redirect_valid", redirect_valid, exp.redirect);
                    if (exp.rf_we) begin
                        check_rf(rf_rd, rf_data, exp.rd, exp.data);
                    end
                    if (exp.store) begin
                        check_store(store_tag, exp.tag);
                    end
                    if (exp.redirect) begin
                        check_redirect(redirect_pc, exp.pc);
                        // younger ones never commit
                        pending.delete();
                    end
                    commits++;
                end
            end
        end
    end

    initial begin
        rng             = SEED;
        rst_n           = 1'b0;
        disp_valid      = 1'b0;
        disp_rd         = '0;
        disp_is_store   = 1'b0;
        disp_pred_taken = 1'b0;
        cpl_valid       = 1'b0;
        cpl_tag         = '0;
        cpl_data        = '0;
        cpl_taken       = 1'b0;
        cpl_target      = '0;
        retire_ready    = 1'b0;
        want_disp       = 1'b0;
        marker          = 1'b0;
        next_tag        = '0;
        commits         = 0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        check_flag("disp_ready", disp_ready, 1'b1);
        check_flag("rf_we", rf_we, 1'b0);
        check_flag("store_commit", store_commit, 1'b0);
        check_flag("redirect_valid", redirect_valid, 1'b0);
        check_tag(disp_tag, '0);

        run_mix(40, 0, 0, 0, 100);
        run_mix(60, 0, 0, 0, 70);
        run_mix(60, 30, 0, 0, 80);
        fill_blocked();
        // branch heavy, about half mispredicted
        run_mix(80, 10, 40, 20, 90);
        run_mix(N_RANDOM, 20, 20, 15, 85);

        if (commits < MIN_COMMITS) begin
            $display("only %0d commits observed", commits);
            $display("TEST FAIL");
            $fatal(1, "too few commits");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* rob_chk.sv */
module rob_chk (
    input logic                       clk,
    input logic                       rst_n,
    input logic [rob_pkg::CRED_W-1:0] credits,
    input logic                       credit_return
);
    import rob_pkg::*;

    // credit count never above the number of slots
    credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CRED_W'(ROB_DEPTH))
        else $error("credit count %0d above buffer depth", credits);

    // a returned credit belongs to a slot that was handed out
    no_return_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        credit_return |-> (credits != CRED_W'(ROB_DEPTH)))
        else $error("credit returned while every credit is already free");

endmodule

bind rob_dispatch rob_chk u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .credits       (credits),
    .credit_return (credit_return)
);

/* rob_top.sv */
module rob_top (
    input  logic              clk,
    input  logic              rst_n,

    // dispatch
    input  logic              disp_valid,
    input  rob_pkg::reg_idx_t disp_rd,
    input  logic              disp_is_store,
    input  logic              disp_pred_taken,
    output logic              disp_ready,
    output rob_pkg::rob_tag_t disp_tag,

    // completion
    input  logic              cpl_valid,
    input  rob_pkg::rob_tag_t cpl_tag,
    input  rob_pkg::data_t    cpl_data,
    input  logic              cpl_taken,
    input  rob_pkg::data_t    cpl_target,

    // commit
    input  logic              retire_ready,
    output logic              rf_we,
    output rob_pkg::reg_idx_t rf_rd,
    output rob_pkg::data_t    rf_data,
    output logic              store_commit,
    output rob_pkg::rob_tag_t store_tag,
    output logic              redirect_valid,
    output rob_pkg::data_t    redirect_pc
);

    logic credit_return;
    logic flush;

    rob_alloc_if alloc_bus ();
    rob_head_if  head_bus ();

    rob_dispatch u_dispatch (
        .clk             (clk),
        .rst_n           (rst_n),
        .disp_valid      (disp_valid),
        .disp_rd         (disp_rd),
        .disp_is_store   (disp_is_store),
        .disp_pred_taken (disp_pred_taken),
        .credit_return   (credit_return),
        .flush           (flush),
        .disp_ready      (disp_ready),
        .disp_tag        (disp_tag),
        .alloc           (alloc_bus.producer)
    );

    rob_buffer u_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpl_valid  (cpl_valid),
        .cpl_tag    (cpl_tag),
        .cpl_data   (cpl_data),
        .cpl_taken  (cpl_taken),
        .cpl_target (cpl_target),
        .alloc      (alloc_bus.buffer),
        .head       (head_bus.buffer)
    );

    rob_retire u_retire (
        .clk            (clk),
        .rst_n          (rst_n),
        .retire_ready   (retire_ready),
        .rf_we          (rf_we),
        .rf_rd          (rf_rd),
        .rf_data        (rf_data),
        .store_commit   (store_commit),
        .store_tag      (store_tag),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .credit_return  (credit_return),
        .flush          (flush),
        .head           (head_bus.retire)
    );

endmodule

/* rob_retire.sv */
module rob_retire (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              retire_ready,
    output logic              rf_we,
    output rob_pkg::reg_idx_t rf_rd,
    output rob_pkg::data_t    rf_data,
    output logic              store_commit,
    output rob_pkg::rob_tag_t store_tag,
    output logic              redirect_valid,
    output rob_pkg::data_t    redirect_pc,
    output logic              credit_return,
    output logic              flush,
    rob_head_if.retire        head
);
    import rob_pkg::*;

    rob_entry_t entry;
    logic       pop;
    logic       mispredict;
    logic       writes_rf;

    assign entry = head.head_entry;

    // younger entries must not leave during the flush cycle
    assign pop = head.head_valid && retire_ready && !flush;

    assign mispredict = entry.taken != entry.pred_taken;
    assign writes_rf  = !entry.is_store && (entry.rd != '0);

    assign head.pop   = pop;
    assign head.flush = flush;

    // commit strobes, one cycle each
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rf_we          <= 1'b0;
            store_commit   <= 1'b0;
            redirect_valid <= 1'b0;
            flush          <= 1'b0;
            credit_return  <= 1'b0;
        end else begin
            rf_we          <= pop && writes_rf;
            store_commit   <= pop && entry.is_store;
            redirect_valid <= pop && mispredict;
            flush          <= pop && mispredict;
            credit_return  <= pop;
        end
    end

    // commit payload
    always_ff @(posedge clk) begin
        if (pop) begin
            rf_rd       <= entry.rd;
            rf_data     <= entry.data;
            store_tag   <= head.head_tag;
            redirect_pc <= entry.target;
        end
    end

endmodule

/* rob_buffer.sv */
module rob_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpl_valid,
    input  rob_pkg::rob_tag_t cpl_tag,
    input  rob_pkg::data_t    cpl_data,
    input  logic              cpl_taken,
    input  rob_pkg::data_t    cpl_target,
    rob_alloc_if.buffer       alloc,
    rob_head_if.buffer        head
);
    import rob_pkg::*;

    rob_entry_t             entries [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]   occupied;
    rob_tag_t               head_ptr;
    logic                   cpl_hit;

    // stale or duplicate completions fall through here
    assign cpl_hit = cpl_valid && occupied[cpl_tag] && !entries[cpl_tag].done;

    // head presentation
    assign head.head_valid = occupied[head_ptr] && entries[head_ptr].done;
    assign head.head_tag   = head_ptr;
    assign head.head_entry = entries[head_ptr];

    // slot payload
    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            entries[alloc.tag] <= '{
                rd:         alloc.rd,
                is_store:   alloc.is_store,
                pred_taken: alloc.pred_taken,
                done:       1'b0,
                data:       '0,
                taken:      1'b0,
                target:     '0
            };
        end
        if (cpl_hit) begin
            entries[cpl_tag].data   <= cpl_data;
            entries[cpl_tag].taken  <= cpl_taken;
            entries[cpl_tag].target <= cpl_target;
            entries[cpl_tag].done   <= 1'b1;
        end
    end

    // occupancy tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied <= '0;
        end else if (head.flush) begin
            occupied <= '0;
        end else begin
            if (alloc.valid) begin
                occupied[alloc.tag] <= 1'b1;
            end
            // tail never reaches a slot still in use, so no clash with alloc
            if (head.pop) begin
                occupied[head_ptr] <= 1'b0;
            end
        end
    end

    // head pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
        end else if (head.flush) begin
            head_ptr <= '0;
        end else if (head.pop) begin
            head_ptr <= head_ptr + 1'b1;
        end
    end

endmodule

/* rob_dispatch.sv */
module rob_dispatch (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              disp_valid,
    input  rob_pkg::reg_idx_t disp_rd,
    input  logic              disp_is_store,
    input  logic              disp_pred_taken,
    input  logic              credit_return,
    input  logic              flush,
    output logic              disp_ready,
    output rob_pkg::rob_tag_t disp_tag,
    rob_alloc_if.producer     alloc
);
    import rob_pkg::*;

    logic [CRED_W-1:0] credits;
    rob_tag_t          tail;
    logic              accept;

    // no new entries while the buffer is being cleared
    assign disp_ready = (credits != '0) && !flush;
    assign accept     = disp_valid && disp_ready;

    // tag is the tail slot, known before the edge
    assign disp_tag = tail;

    assign alloc.valid      = accept;
    assign alloc.tag        = tail;
    assign alloc.rd         = disp_rd;
    assign alloc.is_store   = disp_is_store;
    assign alloc.pred_taken = disp_pred_taken;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail <= '0;
        end else if (flush) begin
            tail <= '0;
        end else if (accept) begin
            tail <= tail + 1'b1;
        end
    end

    // one credit per free slot, returned by retire
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CRED_W'(ROB_DEPTH);
        end else if (flush) begin
            // full refill, pending returns are dropped
            credits <= CRED_W'(ROB_DEPTH);
        end else begin
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* rob_head_if.sv */
interface rob_head_if;
    import rob_pkg::*;

    // head slot, valid only when occupied and done
    logic       head_valid;
    rob_tag_t   head_tag;
    rob_entry_t head_entry;

    // retire side controls
    logic       pop;
    logic       flush;

    modport buffer (
        output head_valid,
        output head_tag,
        output head_entry,
        input  pop,
        input  flush
    );

    modport retire (
        input  head_valid,
        input  head_tag,
        input  head_entry,
        output pop,
        output flush
    );

endinterface

/* rob_alloc_if.sv */
interface rob_alloc_if;
    import rob_pkg::*;

    // one-cycle write strobe per accepted dispatch
    logic     valid;
    rob_tag_t tag;
    reg_idx_t rd;
    logic     is_store;
    logic     pred_taken;

    modport producer (
        output valid,
        output tag,
        output rd,
        output is_store,
        output pred_taken
    );

    modport buffer (
        input valid,
        input tag,
        input rd,
        input is_store,
        input pred_taken
    );

endinterface

/* rob_pkg.sv */
package rob_pkg;

    // buffer geometry
    localparam int ROB_DEPTH = 16;
    localparam int TAG_W     = $clog2(ROB_DEPTH);

    // architectural widths
    localparam int REG_W  = 5;
    localparam int DATA_W = 32;

    // credit counter holds 0..ROB_DEPTH
    localparam int CRED_W = TAG_W + 1;

    typedef logic [TAG_W-1:0]  rob_tag_t;
    typedef logic [REG_W-1:0]  reg_idx_t;
    typedef logic [DATA_W-1:0] data_t;

    // one reorder buffer slot
    typedef struct packed {
        reg_idx_t rd;
        logic     is_store;
        logic     pred_taken;
        logic     done;
        data_t    data;
        logic     taken;
        data_t    target;
    } rob_entry_t;

endpackage
